/* hdl/azLspPkg.sv */
`default_nettype none

package azLspPkg;

	// Operator selects on the shared operator port
	typedef enum logic [3:0]
	{
		OP_L_MULT,
		OP_L_MAC,
		OP_L_MSU,
		OP_L_ADD,
		OP_L_SUB,
		OP_ADD,
		OP_SUB,
		OP_MULT,
		OP_SHR,
		OP_L_SHR,
		OP_L_SHL,
		OP_NORM_S
	} opCodeE;

	typedef struct packed
	{
		logic [15:0] hi;
		logic [15:0] lo;
	} opHalvesT;

	// Long operators take word, short ones and shift counts take half.lo
	typedef union packed
	{
		logic [31:0] word;
		opHalvesT half;
	} opWordU;

	////////////////////
	// Saturation limits
	localparam logic [31:0] MAX_32 = 32'h7fff_ffff;
	localparam logic [31:0] MIN_32 = 32'h8000_0000;
	localparam logic [31:0] MAX_16 = 32'h0000_7fff;
	localparam logic [31:0] MIN_16 = 32'hffff_8000;

	// Control register, bit 0 is testMode
	localparam logic [31:0] CTRL_ADDR = 32'h0001_0000;

endpackage

`default_nettype wire

/* hdl/seqOpIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake to the multi-cycle shift and normalize unit
interface seqOpIf;

	logic start;
	logic isNorm;
	logic [31:0] var1;
	logic [15:0] shift;
	logic [31:0] result;
	logic overflow;
	logic done;

	modport master
	(
		output start,
		output isNorm,
		output var1,
		output shift,
		input result,
		input overflow,
		input done
	);

	modport slave
	(
		input start,
		input isNorm,
		input var1,
		input shift,
		output result,
		output overflow,
		output done
	);

endinterface

`default_nettype wire

/* hdl/scratchMemIf.sv */
`timescale 1ns/1ps
`default_nettype none

// One requester path into the scratch memory
interface scratchMemIf
#(
	parameter int ADDR_W = 12
);

	logic [ADDR_W-1:0] rdAddr;
	logic [ADDR_W-1:0] wrAddr;
	logic [31:0] wrData;
	logic wrEn;
	logic [31:0] rdData;

	modport requester
	(
		output rdAddr,
		output wrAddr,
		output wrData,
		output wrEn,
		input rdData
	);

	modport memory
	(
		input rdAddr,
		input wrAddr,
		input wrData,
		input wrEn,
		output rdData
	);

endinterface

`default_nettype wire

/* hdl/scratchMem.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchMem
#(
	parameter int ADDR_W = 12
)
(
	input wire clk,
	scratchMemIf.memory mem
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [31:0] memArray [0:DEPTH-1];

	////////////////////
	// Write port
	always_ff @(posedge clk)
	begin
		if (mem.wrEn)
		begin
			memArray[mem.wrAddr] <= mem.wrData;
		end
	end

	////////////////////
	// Registered read port
	// Same-address read during a write sees the old word
	always_ff @(posedge clk)
	begin
		mem.rdData <= memArray[mem.rdAddr];
	end

endmodule

`default_nettype wire

/* hdl/testAccessPort.sv */
`timescale 1ns/1ps
`default_nettype none

module testAccessPort import azLspPkg::*;
#(
	parameter int ADDR_W = 12
)
(
	input wire clk,
	input wire rstN,
	input wire pSel,
	input wire pEnable,
	input wire pWrite,
	input wire [31:0] pAddr,
	input wire [31:0] pWData,
	output logic [31:0] pRData,
	output logic pReady,
	output logic pSlvErr,
	input wire [ADDR_W-1:0] lspRdAddr,
	input wire [ADDR_W-1:0] lspWrAddr,
	input wire [31:0] lspWrData,
	input wire lspWrEn,
	output logic [31:0] lspRdData,
	scratchMemIf.requester mem
);

	logic testMode;
	logic rdWait;
	logic access;
	logic unaligned;
	logic inRange;
	logic isCtrl;
	logic memHit;
	logic err;
	logic apbRd;
	logic [ADDR_W-1:0] testAddr;

	////////////////////
	// Address decode
	assign access = pSel && pEnable;
	assign unaligned = pAddr[1:0] != 2'b00;
	assign inRange = pAddr[31:ADDR_W+2] == '0;
	assign isCtrl = pAddr == CTRL_ADDR;
	assign memHit = inRange && !isCtrl;
	assign err = unaligned || (!inRange && !isCtrl) || (pWrite && memHit && !testMode);
	assign testAddr = pAddr[ADDR_W+1:2];
	assign apbRd = pSel && !pWrite && memHit;

	// Writes finish at once, good reads wait one cycle for the RAM
	assign pReady = access && (pWrite || err || rdWait);
	assign pSlvErr = pReady && err;
	assign pRData = isCtrl ? {31'b0, testMode} : mem.rdData;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			testMode <= 1'b0;
			rdWait <= 1'b0;
		end
		else
		begin
			rdWait <= access && !pWrite && !err && !rdWait;
			if (access && pWrite && isCtrl)
			begin
				testMode <= pWData[0];
			end
		end
	end

	////////////////////
	// Engine or test host onto the memory
	assign mem.rdAddr = (testMode || apbRd) ? testAddr : lspRdAddr;
	assign mem.wrAddr = testMode ? testAddr : lspWrAddr;
	assign mem.wrData = testMode ? pWData : lspWrData;
	assign mem.wrEn = testMode ? (access && pWrite && memHit && !err) : lspWrEn;
	assign lspRdData = mem.rdData;

endmodule

`default_nettype wire

/* hdl/shiftNormUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module shiftNormUnit import azLspPkg::*;
(
	input wire clk,
	input wire rstN,
	seqOpIf.slave seq
);

	typedef enum logic {IDLE, RUN} stateE;

	stateE state;
	logic [31:0] work;
	logic [5:0] cnt;
	logic isNormQ;
	logic goRight;
	logic [16:0] shiftMag;
	logic normStop;
	logic shlSat;
	logic finish;

	// Negative counts shift right by this magnitude
	assign shiftMag = seq.shift[15] ? -{seq.shift[15], seq.shift} : {1'b0, seq.shift};

	// Also stops at once for 0 and -1 with a count of 0
	assign normStop = (work[15] != work[14]) || (work[15:0] == 16'h0000) ||
		(work[15:0] == 16'hffff);
	assign shlSat = !goRight && (cnt != 6'd0) && (work[31] != work[30]);
	assign finish = isNormQ ? normStop : ((cnt == 6'd0) || shlSat);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			cnt <= '0;
			isNormQ <= 1'b0;
			goRight <= 1'b0;
			seq.done <= 1'b0;
		end
		else
		begin
			seq.done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (seq.start)
					begin
						state <= RUN;
						isNormQ <= seq.isNorm;
						goRight <= seq.shift[15] && !seq.isNorm;
						// Past 32 steps the answer no longer changes
						if (seq.isNorm)
							cnt <= '0;
						else
							cnt <= (shiftMag > 17'd32) ? 6'd32 : shiftMag[5:0];
					end
				end
				RUN:
				begin
					if (finish)
					begin
						state <= IDLE;
						seq.done <= 1'b1;
					end
					else
					begin
						cnt <= isNormQ ? cnt + 6'd1 : cnt - 6'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// One bit per cycle
	always_ff @(posedge clk)
	begin
		if (state == IDLE && seq.start)
			work <= seq.isNorm ? {16'h0000, seq.var1[15:0]} : seq.var1;
		else if (state == RUN && !finish)
			work <= goRight ? {work[31], work[31:1]} : {work[30:0], 1'b0};

		if (state == RUN && finish)
		begin
			if (isNormQ)
				{seq.overflow, seq.result} <= {1'b0, 26'b0, cnt};
			else if (shlSat)
				{seq.overflow, seq.result} <= {1'b1, work[31] ? MIN_32 : MAX_32};
			else
				{seq.overflow, seq.result} <= {1'b0, work};
		end
	end

endmodule

`default_nettype wire

/* hdl/basicOpUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module basicOpUnit import azLspPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire opStart,
	input wire opCodeE opCode,
	input wire opWordU opA,
	input wire opWordU opB,
	input wire opWordU opC,
	output logic [31:0] opResult,
	output logic opOverflow,
	output logic opDone,
	output logic opBusy
);

	seqOpIf seq ();

	logic accept;
	logic isSeq;
	logic [31:0] aShort;
	logic [31:0] bShort;
	logic signed [31:0] prod;
	logic [32:0] lMult;
	logic [32:0] macAcc;
	logic [32:0] msuAcc;
	logic [32:0] alu;

	function automatic logic signed [63:0] sx(input logic [31:0] x);
		return {{32{x[31]}}, x};
	endfunction

	// Clamp to the 16 or 32 bit range, overflow in bit 32
	function automatic logic [32:0] saturate(input logic signed [63:0] v, input logic is16);
		logic signed [63:0] hiLim;
		logic signed [63:0] loLim;
		hiLim = is16 ? sx(MAX_16) : sx(MAX_32);
		loLim = is16 ? sx(MIN_16) : sx(MIN_32);
		if (v > hiLim)
			return {1'b1, hiLim[31:0]};
		else if (v < loLim)
			return {1'b1, loLim[31:0]};
		return {1'b0, v[31:0]};
	endfunction

	// shr and L_shr, negative counts turn into a saturating left shift
	function automatic logic [32:0] shiftSat(input logic signed [31:0] x,
		input logic signed [15:0] cnt, input logic is16);
		logic [16:0] mag;
		logic signed [63:0] wide;
		if (!cnt[15])
			return {1'b0, x >>> ((cnt > 16'sd31) ? 31 : cnt)};
		mag = -{cnt[15], cnt};
		wide = sx(x);
		wide = wide <<< ((mag > 17'd32) ? 32 : mag);
		return saturate(wide, is16);
	endfunction

	////////////////////
	// Single-cycle datapath
	assign aShort = {{16{opA.half.lo[15]}}, opA.half.lo};
	assign bShort = {{16{opB.half.lo[15]}}, opB.half.lo};
	assign prod = $signed(opA.half.lo) * $signed(opB.half.lo);

	// Doubled product, only 0x8000 * 0x8000 saturates
	assign lMult = saturate($signed({{31{prod[31]}}, prod, 1'b0}), 1'b0);
	assign macAcc = saturate(sx(opC.word) + sx(lMult[31:0]), 1'b0);
	assign msuAcc = saturate(sx(opC.word) - sx(lMult[31:0]), 1'b0);

	always_comb
	begin
		case (opCode)
			OP_L_MULT: alu = lMult;
			OP_L_MAC: alu = {lMult[32] | macAcc[32], macAcc[31:0]};
			OP_L_MSU: alu = {lMult[32] | msuAcc[32], msuAcc[31:0]};
			OP_L_ADD: alu = saturate(sx(opA.word) + sx(opB.word), 1'b0);
			OP_L_SUB: alu = saturate(sx(opA.word) - sx(opB.word), 1'b0);
			OP_ADD: alu = saturate(sx(aShort) + sx(bShort), 1'b1);
			OP_SUB: alu = saturate(sx(aShort) - sx(bShort), 1'b1);
			OP_MULT: alu = saturate(sx(prod) >>> 15, 1'b1);
			OP_SHR: alu = shiftSat(aShort, opB.half.lo, 1'b1);
			OP_L_SHR: alu = shiftSat(opA.word, opB.half.lo, 1'b0);
			default: alu = '0;
		endcase
	end

	////////////////////
	// Dispatch to the multi-cycle unit
	assign isSeq = (opCode == OP_L_SHL) || (opCode == OP_NORM_S);
	assign accept = opStart && !opBusy;
	assign seq.start = accept && isSeq;
	assign seq.isNorm = opCode == OP_NORM_S;
	assign seq.var1 = opA.word;
	assign seq.shift = opB.half.lo;

	shiftNormUnit i_shiftNormUnit
	(
		.clk (clk),
		.rstN (rstN),
		.seq (seq)
	);

	// Shared result register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			opResult <= '0;
			opOverflow <= 1'b0;
			opDone <= 1'b0;
			opBusy <= 1'b0;
		end
		else
		begin
			opDone <= 1'b0;
			if (accept && !isSeq)
			begin
				opResult <= alu[31:0];
				opOverflow <= alu[32];
				opDone <= 1'b1;
			end
			else if (accept)
			begin
				opBusy <= 1'b1;
			end
			else if (seq.done)
			begin
				opResult <= seq.result;
				opOverflow <= seq.overflow;
				opDone <= 1'b1;
				opBusy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/azLspPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module azLspPipe import azLspPkg::*;
#(
	parameter int ADDR_W = 12
)
(
	input wire clk,
	input wire rstN,

	// Operator port
	input wire opStart,
	input wire opCodeE opCode,
	input wire opWordU opA,
	input wire opWordU opB,
	input wire opWordU opC,
	output logic [31:0] opResult,
	output logic opOverflow,
	output logic opDone,
	output logic opBusy,

	// Engine side of the scratch memory
	input wire [ADDR_W-1:0] lspRdAddr,
	input wire [ADDR_W-1:0] lspWrAddr,
	input wire [31:0] lspWrData,
	input wire lspWrEn,
	output logic [31:0] lspRdData,

	// APB test port
	input wire pSel,
	input wire pEnable,
	input wire pWrite,
	input wire [31:0] pAddr,
	input wire [31:0] pWData,
	output logic [31:0] pRData,
	output logic pReady,
	output logic pSlvErr
);

	scratchMemIf #(.ADDR_W(ADDR_W)) memSide ();

	////////////////////
	// Math
	basicOpUnit i_basicOpUnit
	(
		.clk (clk),
		.rstN (rstN),
		.opStart (opStart),
		.opCode (opCode),
		.opA (opA),
		.opB (opB),
		.opC (opC),
		.opResult (opResult),
		.opOverflow (opOverflow),
		.opDone (opDone),
		.opBusy (opBusy)
	);

	////////////////////
	// Memory and its test access
	testAccessPort #(.ADDR_W(ADDR_W)) i_testAccessPort
	(
		.clk (clk),
		.rstN (rstN),
		.pSel (pSel),
		.pEnable (pEnable),
		.pWrite (pWrite),
		.pAddr (pAddr),
		.pWData (pWData),
		.pRData (pRData),
		.pReady (pReady),
		.pSlvErr (pSlvErr),
		.lspRdAddr (lspRdAddr),
		.lspWrAddr (lspWrAddr),
		.lspWrData (lspWrData),
		.lspWrEn (lspWrEn),
		.lspRdData (lspRdData),
		.mem (memSide)
	);

	scratchMem #(.ADDR_W(ADDR_W)) i_scratchMem
	(
		.clk (clk),
		.mem (memSide)
	);

endmodule

`default_nettype wire

/* sim/azLspPipe_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake rules on the operator and APB ports
module azLspPipeSva
(
	input wire clk,
	input wire rstN,
	input wire opStart,
	input wire opBusy,
	input wire opDone,
	input wire pSel,
	input wire pEnable,
	input wire pWrite,
	input wire pReady,
	input wire pSlvErr
);

	int failCount = 0;

	// Done is a single-cycle pulse
	doneOnePulse: assert property (@(posedge clk) disable iff (!rstN)
		opDone |=> !opDone)
		else
		begin
			failCount++;
			$error("opDone held for more than one cycle");
		end

	// An accepted start gives done or busy next cycle
	acceptTakesEffect: assert property (@(posedge clk) disable iff (!rstN)
		(opStart && !opBusy) |=> (opDone || opBusy))
		else
		begin
			failCount++;
			$error("accepted opStart was not taken up");
		end

	busyEndsWithDone: assert property (@(posedge clk) disable iff (!rstN)
		$fell(opBusy) |-> opDone)
		else
		begin
			failCount++;
			$error("opBusy fell without opDone");
		end

	// First access cycle of a read ends only on an error
	readFirstAccess: assert property (@(posedge clk) disable iff (!rstN)
		(pSel && $rose(pEnable) && !pWrite) |-> (pReady == pSlvErr))
		else
		begin
			failCount++;
			$error("APB read skipped its wait state or raised pSlvErr without pReady");
		end

endmodule

`default_nettype wire

/* sim/azLspPipeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module azLspPipeTb import azLspPkg::*;
();

	localparam int ADDR_W = 12;

	logic clk;
	logic rstN;
	logic opStart;
	opCodeE opCode;
	opWordU opA;
	opWordU opB;
	opWordU opC;
	logic [31:0] opResult;
	logic opOverflow;
	logic opDone;
	logic opBusy;
	logic [ADDR_W-1:0] lspRdAddr;
	logic [ADDR_W-1:0] lspWrAddr;
	logic [31:0] lspWrData;
	logic lspWrEn;
	logic [31:0] lspRdData;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [31:0] pAddr;
	logic [31:0] pWData;
	logic [31:0] pRData;
	logic pReady;
	logic pSlvErr;
	int checks;
	int errors;

	azLspPipe #(.ADDR_W(ADDR_W)) i_azLspPipe (.*);

	bind azLspPipe azLspPipeSva i_azLspPipeSva
	(
		.clk (clk),
		.rstN (rstN),
		.opStart (opStart),
		.opBusy (opBusy),
		.opDone (opDone),
		.pSel (pSel),
		.pEnable (pEnable),
		.pWrite (pWrite),
		.pReady (pReady),
		.pSlvErr (pSlvErr)
	);

	always #2 clk = ~clk;

	task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at time %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		errors++;
		$display("Timeout: %s did not arrive within 50 cycles", what);
	endtask

	////////////////////
	// Reference models
	function automatic logic [32:0] sat32(input longint v);
		if (v > 64'sd2147483647)
			return {1'b1, MAX_32};
		if (v < -64'sd2147483648)
			return {1'b1, MIN_32};
		return {1'b0, v[31:0]};
	endfunction

	function automatic logic [32:0] sat16(input longint v);
		if (v > 64'sd32767)
			return {1'b1, MAX_16};
		if (v < -64'sd32768)
			return {1'b1, MIN_16};
		return {1'b0, v[31:0]};
	endfunction

	// Negative count means a saturating left shift
	function automatic logic [32:0] shiftModel(input longint x, input longint n, input logic is16);
		longint v;
		if (n >= 0)
		begin
			v = x >>> ((n > 31) ? 31 : n);
			return {1'b0, v[31:0]};
		end
		v = x <<< ((-n > 32) ? 32 : -n);
		return is16 ? sat16(v) : sat32(v);
	endfunction

	function automatic logic [32:0] arithModel(input opCodeE code, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		longint sa;
		longint sb;
		longint la;
		longint lb;
		longint lc;
		logic [32:0] m;
		logic [32:0] r;
		sa = $signed(a[15:0]);
		sb = $signed(b[15:0]);
		la = $signed(a);
		lb = $signed(b);
		lc = $signed(c);
		// Only 0x8000 * 0x8000 overflows the doubled product
		if (a[15:0] == 16'h8000 && b[15:0] == 16'h8000)
			m = {1'b1, MAX_32};
		else
			m = {1'b0, 32'(sa * sb * 2)};
		case (code)
			OP_L_MULT: r = m;
			OP_L_MAC: r = sat32(lc + longint'($signed(m[31:0])));
			OP_L_MSU: r = sat32(lc - longint'($signed(m[31:0])));
			OP_L_ADD: r = sat32(la + lb);
			OP_L_SUB: r = sat32(la - lb);
			OP_ADD: r = sat16(sa + sb);
			OP_SUB: r = sat16(sa - sb);
			OP_MULT: r = sat16((sa * sb) >>> 15);
			OP_SHR: r = shiftModel(sa, sb, 1'b1);
			default: r = shiftModel(la, sb, 1'b0);
		endcase
		if (code == OP_L_MAC || code == OP_L_MSU)
			r[32] = r[32] | m[32];
		return r;
	endfunction

	// Stops saturated before the sign would change
	function automatic logic [32:0] lShlModel(input logic [31:0] x, input int n);
		logic signed [31:0] v;
		int i;
		v = x;
		for (i = 0; i < n; i++)
		begin
			if (v > 32'sh3fff_ffff)
				return {1'b1, MAX_32};
			if (v < -32'sh4000_0000)
				return {1'b1, MIN_32};
			v = v <<< 1;
		end
		return {1'b0, v};
	endfunction

	function automatic int normModel(input logic [15:0] x);
		int n;
		logic [15:0] v;
		n = 0;
		v = x;
		if (x == 16'h0000 || x == 16'hffff)
			return 0;
		while (v[15] == v[14])
		begin
			v = v << 1;
			n++;
		end
		return n;
	endfunction

	function automatic logic [31:0] memAddr(input logic [ADDR_W-1:0] idx);
		return 32'({idx, 2'b00});
	endfunction

	////////////////////
	// Bus drivers
	task automatic runOp(input opCodeE code, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c, output int latency, output logic sawBusy);
		@(posedge clk);
		opStart <= 1'b1;
		opCode <= code;
		opA.word <= a;
		opB.word <= b;
		opC.word <= c;
		@(posedge clk);
		opStart <= 1'b0;
		latency = 0;
		sawBusy = 1'b0;
		do
		begin
			@(negedge clk);
			latency++;
			sawBusy = sawBusy | opBusy;
		end
		while (!opDone && latency < 50);
		if (!opDone)
			reportTimeout("opDone");
	endtask

	task automatic apbXfer(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int waits);
		@(posedge clk);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= write;
		pAddr <= addr;
		pWData <= wdata;
		@(posedge clk);
		pEnable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pReady && waits < 50)
		begin
			@(negedge clk);
			waits++;
		end
		if (!pReady)
			reportTimeout("pReady");
		rdata = pRData;
		err = pSlvErr;
		@(posedge clk);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rdata;
		logic err;
		int waits;
		apbXfer(1'b1, addr, data, rdata, err, waits);
		checkEq(waits, 0, $sformatf("APB write %h wait states", addr));
		checkEq(err, expErr, $sformatf("APB write %h pSlvErr", addr));
	endtask

	task automatic apbRead(input logic [31:0] addr, input logic [31:0] expData, input logic expErr);
		logic [31:0] rdata;
		logic err;
		int waits;
		apbXfer(1'b0, addr, 32'h0, rdata, err, waits);
		// Good reads take exactly one wait state
		checkEq(waits, expErr ? 0 : 1, $sformatf("APB read %h wait states", addr));
		checkEq(err, expErr, $sformatf("APB read %h pSlvErr", addr));
		if (!expErr)
			checkEq(rdata, expData, $sformatf("APB read %h data", addr));
	endtask

	////////////////////
	// Tests
	task automatic checkArith(input opCodeE code, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c);
		logic [32:0] exp;
		int latency;
		logic sawBusy;
		exp = arithModel(code, a, b, c);
		runOp(code, a, b, c, latency, sawBusy);
		checkEq(latency, 1, $sformatf("%s latency", code.name()));
		checkEq(opResult, exp[31:0], $sformatf("%s a=%h b=%h c=%h", code.name(), a, b, c));
		checkEq(opOverflow, exp[32], $sformatf("%s overflow a=%h b=%h", code.name(), a, b));
	endtask

	task automatic arithSweep();
		opCodeE code;
		logic [31:0] b;
		int i;
		checkArith(OP_L_MULT, 32'h0000_8000, 32'h0000_8000, 32'h0);
		checkArith(OP_L_MAC, 32'h0000_8000, 32'h0000_8000, 32'h1234_5678);
		checkArith(OP_L_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h0);
		checkArith(OP_L_SUB, 32'h8000_0000, 32'h0000_0001, 32'h0);
		checkArith(OP_ADD, 32'h0000_7fff, 32'h0000_0001, 32'h0);
		checkArith(OP_MULT, 32'h0000_8000, 32'h0000_8000, 32'h0);
		checkArith(OP_SHR, 32'h0000_0001, 32'h0000_fff0, 32'h0);
		for (i = 0; i < 300; i++)
		begin
			code = opCodeE'(i % 10);
			b = $urandom();
			if (code == OP_SHR || code == OP_L_SHR)
				b[15:0] = 16'($urandom_range(80)) - 16'd40;
			checkArith(code, $urandom(), b, $urandom());
		end
	endtask

	task automatic shlSweep();
		logic [31:0] vals [5];
		logic [32:0] exp;
		int latency;
		logic sawBusy;
		int v;
		int n;
		vals = '{32'h0000_0001, 32'h0000_1234, 32'hffff_fffd, 32'h4000_0000, 32'h9abc_def0};
		for (v = 0; v < 5; v++)
		begin
			for (n = 0; n < 32; n++)
			begin
				exp = lShlModel(vals[v], n);
				runOp(OP_L_SHL, vals[v], {16'($urandom()), 16'(n)}, 32'h0, latency, sawBusy);
				checkEq(opResult, exp[31:0], $sformatf("L_shl %h by %0d", vals[v], n));
				checkEq(opOverflow, exp[32], $sformatf("L_shl %h by %0d overflow", vals[v], n));
				checkEq(sawBusy, 1'b1, "L_shl opBusy");
				checkEq(latency >= 2, 1'b1, "L_shl latency");
			end
		end
	endtask

	task automatic normSweep();
		logic [15:0] x;
		int latency;
		logic sawBusy;
		int i;
		for (i = 0; i < 24; i++)
		begin
			case (i)
				0: x = 16'h0000;
				1: x = 16'hffff;
				2: x = 16'h0001;
				3: x = 16'h4000;
				default: x = 16'($urandom());
			endcase
			runOp(OP_NORM_S, {16'($urandom()), x}, $urandom(), 32'h0, latency, sawBusy);
			checkEq(opResult, normModel(x), $sformatf("norm_s %h", x));
			checkEq(opOverflow, 1'b0, $sformatf("norm_s %h overflow", x));
			checkEq(sawBusy, 1'b1, "norm_s opBusy");
		end
	endtask

	task automatic memLoadDump();
		logic [31:0] shadow [1 << ADDR_W];
		logic [ADDR_W-1:0] idxQ [$];
		logic [ADDR_W-1:0] idx;
		logic [31:0] data;
		int i;
		apbWrite(CTRL_ADDR, 32'h1, 1'b0);
		apbRead(CTRL_ADDR, 32'h1, 1'b0);
		for (i = 0; i < 16; i++)
		begin
			idx = ADDR_W'($urandom());
			data = $urandom();
			shadow[idx] = data;
			idxQ.push_back(idx);
			apbWrite(memAddr(idx), data, 1'b0);
		end
		foreach (idxQ[i])
			apbRead(memAddr(idxQ[i]), shadow[idxQ[i]], 1'b0);
	endtask

	task automatic enginePortSelect();
		logic [ADDR_W-1:0] idx;
		logic [31:0] data;
		idx = ADDR_W'($urandom());
		data = $urandom();
		apbWrite(CTRL_ADDR, 32'h0, 1'b0);
		@(posedge clk);
		lspWrAddr <= idx;
		lspWrData <= data;
		lspWrEn <= 1'b1;
		@(posedge clk);
		lspWrEn <= 1'b0;
		lspRdAddr <= idx;
		@(posedge clk);
		@(negedge clk);
		checkEq(lspRdData, data, "engine read after write");
		// Memory writes need testMode
		apbWrite(memAddr(idx), ~data, 1'b1);
		apbRead(memAddr(idx), data, 1'b0);
		apbWrite(CTRL_ADDR, 32'h1, 1'b0);
		@(posedge clk);
		lspWrAddr <= idx;
		lspWrData <= ~data;
		lspWrEn <= 1'b1;
		@(posedge clk);
		lspWrEn <= 1'b0;
		apbRead(memAddr(idx), data, 1'b0);
	endtask

	task automatic apbErrorCases();
		apbWrite(32'h0000_0002, 32'h0, 1'b1);
		apbRead(32'h0000_0006, 32'h0, 1'b1);
		apbWrite(32'(4 << ADDR_W), 32'h0, 1'b1);
		apbRead(32'h0002_0000, 32'h0, 1'b1);
	endtask

	initial
	begin
		void'($urandom(23));
		checks = 0;
		errors = 0;
		clk = 1'b0;
		rstN = 1'b0;
		opStart = 1'b0;
		opCode = OP_L_MULT;
		opA = '0;
		opB = '0;
		opC = '0;
		lspRdAddr = '0;
		lspWrAddr = '0;
		lspWrData = '0;
		lspWrEn = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		repeat (3) @(posedge clk);
		checkEq({opResult, opOverflow, opDone, opBusy, pReady, pSlvErr}, 0, "reset state");
		rstN <= 1'b1;
		arithSweep();
		shlSweep();
		normSweep();
		memLoadDump();
		enginePortSelect();
		apbErrorCases();
		errors += i_azLspPipe.i_azLspPipeSva.failCount;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/azLspPkg.sv
hdl/seqOpIf.sv
hdl/scratchMemIf.sv
hdl/scratchMem.sv
hdl/testAccessPort.sv
hdl/shiftNormUnit.sv
hdl/basicOpUnit.sv
hdl/azLspPipe.sv
sim/azLspPipe_sva.sv
sim/azLspPipeTb.sv

/* Makefile */
TOP = azLspPipeTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^TB PASSED$$" > /dev/null

clean:
	rm -rf obj_dir
